/* bench/rs_testdata.txt */
# dispatch slots 2 1 0 (ctl dest src1 src2), cdb 2 1 0, fu stall, struct_stall, issue 2 1 0
# ctl: 4+class when valid, low digit ready bits; cdb/issue: 40+tag when valid; stall alu ls mult br
test reset_state
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  00 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  00 00 00
test ready_dispatch
43 10 00 00  53 11 00 00  73 12 00 00  00 00 00  0  0  00 00 00
43 13 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  50 51 52
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  53 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  00 00 00
test cdb_wakeup
41 20 05 00  42 21 00 06  00 00 00 00  00 00 00  0  0  00 00 00
00 00 00 00  00 00 00 00  00 00 00 00  05 06 00  0  0  00 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 45  0  0  60 00 00
00 00 00 00  00 00 00 00  00 00 00 00  46 00 00  0  0  61 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  00 00 00
test fu_backpressure
63 30 00 00  63 31 00 00  43 32 00 00  00 00 00  2  0  00 00 00
43 33 00 00  00 00 00 00  00 00 00 00  00 00 00  2  0  72 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  2  0  73 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  2  0  00 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  70 71 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  00 00 00
test full_station
41 10 30 00  41 11 31 00  41 12 32 00  00 00 00  0  0  00 00 00
41 13 33 00  41 14 34 00  41 15 35 00  00 00 00  0  0  00 00 00
41 16 36 00  41 17 37 00  41 18 38 00  00 00 00  0  0  00 00 00
41 19 39 00  41 1A 3A 00  41 1B 3B 00  00 00 00  0  0  00 00 00
41 1C 3C 00  41 1D 3D 00  41 1E 3E 00  00 00 00  0  0  00 00 00
41 1F 3F 00  00 00 00 00  00 00 00 00  00 00 00  0  3  00 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  7  00 00 00
00 00 00 00  00 00 00 00  00 00 00 00  75 00 00  0  7  55 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  3  00 00 00
00 00 00 00  00 00 00 00  00 00 00 00  70 71 72  0  3  50 51 52
00 00 00 00  00 00 00 00  00 00 00 00  73 74 76  0  0  53 54 56
00 00 00 00  00 00 00 00  00 00 00 00  77 78 79  0  0  57 58 59
00 00 00 00  00 00 00 00  00 00 00 00  7A 7B 7C  0  0  5A 5B 5C
00 00 00 00  00 00 00 00  00 00 00 00  7D 7E 7F  0  0  5D 5E 5F
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  00 00 00
test issue_width
41 01 2A 00  51 02 2A 00  71 03 2A 00  00 00 00  0  0  00 00 00
41 04 2A 00  51 05 2A 00  41 06 2A 00  00 00 00  0  0  00 00 00
71 07 2A 00  00 00 00 00  00 00 00 00  00 00 00  0  0  00 00 00
00 00 00 00  00 00 00 00  00 00 00 00  6A 00 00  0  0  41 42 43
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  44 45 46
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  47 00 00
00 00 00 00  00 00 00 00  00 00 00 00  00 00 00  0  0  00 00 00
end

/* sources.f */
verilog/rs_pkg.sv
verilog/rs_alloc.sv
verilog/rs_entry.sv
verilog/rs_issue_select.sv
verilog/rs_top.sv
bench/rs_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the reservation station testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rs_tb -Mdir obj_dir -o rs_tb_sim \
    -f sources.f > build.log 2>&1 ||
    { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/rs_tb_sim > sim.log 2>&1

grep -qx "Finished with no errors" sim.log && echo "Simulation passed" && exit 0 ||
    { echo "Simulation failed, see sim.log"; exit 1; }

/* bench/rs_tb.sv */
`timescale 1ns/1ps

module rs_tb import rs_pkg::*; ();

    localparam int    RESET_CYCLES = 16;
    localparam int    MAX_LINES    = 400;   // Reader stops past this many lines
    localparam int    FIELDS       = 20;    // Tokens on one data line
    localparam string DATA_FILE    = "bench/rs_testdata.txt";

    logic                            clock = 1'b0;
    logic                            reset;
    rs_in_packet    [DISPATCH_W-1:0] rs_in;
    cdb_packet                       cdb;
    fu_stall_packet                  fu_stall;
    rs_issue_packet [DISPATCH_W-1:0] issue_insts;
    logic           [DISPATCH_W-1:0] struct_stall;

    logic [7:0] field [FIELDS];  // Current data line
    int         error_count;
    int         test_errors;
    int         test_cycles;
    int         tests_run;
    int         tests_failed;
    string      test_name;
    bit         file_problem;

    always #5 clock = ~clock;

    rs_top dut0 (
        .clock        (clock),
        .reset        (reset),
        .rs_in        (rs_in),
        .cdb          (cdb),
        .fu_stall     (fu_stall),
        .issue_insts  (issue_insts),
        .struct_stall (struct_stall)
    );

    // ==========================================================
    // Data line decoding
    // ==========================================================
    // ctl high digit is 4 + FU class when valid, low digit the two ready bits
    function automatic rs_in_packet make_dispatch(input logic [7:0] ctl, input logic [7:0] dest,
                                                  input logic [7:0] src1, input logic [7:0] src2);
        rs_in_packet p;
        p              = '0;
        p.info.valid   = ctl[6];
        p.info.fu_sel  = fu_class_t'(ctl[5:4]);
        p.info.op_sel  = dest[4:0];
        p.info.pc      = 32'h0000_1000 + {22'h0, dest, 2'b00};
        p.info.inst    = {24'h00_0013, dest};  // Filler, not checked
        p.info.dest_pr = dest[PR_W-1:0];
        p.info.reg1_pr = src1[PR_W-1:0];
        p.info.reg2_pr = src2[PR_W-1:0];
        p.reg1_ready   = ctl[1];
        p.reg2_ready   = ctl[0];
        return p;
    endfunction

    function automatic cdb_slot_t make_cdb(input logic [7:0] token);
        cdb_slot_t c;
        c.valid = token[6];       // 40 marks a valid slot
        c.tag   = token[PR_W-1:0];
        return c;
    endfunction

    // ==========================================================
    // Drive and check
    // ==========================================================
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            error_count++;
            test_errors++;
        end
    endtask

    // Columns run slot 2 first, matching the issue priority
    task automatic drive_inputs();
        int base;
        for (int s = 0; s < DISPATCH_W; s++) begin
            base        = 4 * (DISPATCH_W - 1 - s);
            rs_in[s]    = make_dispatch(field[base], field[base+1], field[base+2], field[base+3]);
            cdb.slot[s] = make_cdb(field[12 + DISPATCH_W - 1 - s]);
        end
        fu_stall = fu_stall_packet'(field[15][3:0]);  // {alu, ls, mult, branch}
    endtask

    task automatic check_outputs();
        logic [7:0] token;
        check_value($sformatf("%s struct_stall", test_name), 32'(struct_stall),
                    32'(field[16][2:0]));
        for (int s = DISPATCH_W - 1; s >= 0; s--) begin
            token = field[17 + DISPATCH_W - 1 - s];
            check_value($sformatf("%s issue slot %0d valid", test_name, s),
                        32'(issue_insts[s].valid), 32'(token[6]));
            if (token[6]) begin
                check_value($sformatf("%s issue slot %0d dest_pr", test_name, s),
                            32'(issue_insts[s].dest_pr), 32'(token[PR_W-1:0]));
                // Op and pc were built from dest at dispatch
                check_value($sformatf("%s issue slot %0d op_sel", test_name, s),
                            32'(issue_insts[s].op_sel), 32'(token[4:0]));
                check_value($sformatf("%s issue slot %0d pc", test_name, s),
                            issue_insts[s].pc,
                            32'h0000_1000 + {24'h0, token[PR_W-1:0], 2'b00});
            end
        end
    endtask

    // Entered 1 ns after a rising edge, leaves 1 ns after the next one
    task automatic run_cycle(input string line, input int line_no);
        int count;
        count = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            field[0], field[1], field[2], field[3], field[4], field[5], field[6],
            field[7], field[8], field[9], field[10], field[11], field[12], field[13],
            field[14], field[15], field[16], field[17], field[18], field[19]);
        if (count != FIELDS) begin
            $display("Data line %0d has %0d fields instead of %0d", line_no, count, FIELDS);
            file_problem = 1'b1;
        end else begin
            drive_inputs();
            #8;  // Combinational outputs settled well before the edge
            check_outputs();
            test_cycles++;
            @(posedge clock);
            #1;
        end
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("Test %s passed, %0d cycles", test_name, test_cycles);
            end else begin
                tests_failed++;
                $display("Test %s failed, %0d mismatches in %0d cycles",
                         test_name, test_errors, test_cycles);
            end
        end
        test_name   = "";
        test_errors = 0;
        test_cycles = 0;
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        int    fd;
        int    code;
        int    lines_read;
        int    reset_count;
        bit    done;
        bit    seen_end;
        string line;
        string word;
        string name;

        reset        = 1'b1;
        rs_in        = '0;
        cdb          = '0;
        fu_stall     = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        file_problem = 1'b0;
        test_name    = "";
        test_errors  = 0;
        test_cycles  = 0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the data file %s", DATA_FILE);
            file_problem = 1'b1;
        end

        reset_count = 0;
        while (reset_count < RESET_CYCLES) begin
            @(posedge clock);
            reset_count++;
        end
        #1;
        reset = 1'b0;

        done       = (fd == 0);
        seen_end   = 1'b0;
        lines_read = 0;
        while (!done && lines_read < MAX_LINES) begin
            if ($feof(fd) != 0) begin
                done = 1'b1;
            end else begin
                line = "";
                word = "";
                code = $fgets(line, fd);
                lines_read++;
                code = $sscanf(line, "%s", word);
                if (code < 1 || word.substr(0, 0) == "#") begin
                    // Blank or comment line
                end else if (word == "test") begin
                    finish_test();
                    code      = $sscanf(line, "%s %s", word, name);
                    test_name = name;
                end else if (word == "end") begin
                    finish_test();
                    seen_end = 1'b1;
                    done     = 1'b1;
                end else begin
                    run_cycle(line, lines_read);
                end
            end
        end

        if (fd != 0 && !seen_end) begin
            if (lines_read >= MAX_LINES) begin
                $display("Data file is longer than %0d lines, reading stopped", MAX_LINES);
            end else begin
                $display("Data file ended after %0d lines without its end marker", lines_read);
            end
            file_problem = 1'b1;
            finish_test();
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0 && tests_failed == 0 && !file_problem && tests_run > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* verilog/rs_top.sv */
`timescale 1ns/1ps

module rs_top import rs_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  rs_in_packet    [DISPATCH_W-1:0] rs_in,
    input  cdb_packet                       cdb,
    input  fu_stall_packet                  fu_stall,
    output rs_issue_packet [DISPATCH_W-1:0] issue_insts,
    output logic           [DISPATCH_W-1:0] struct_stall
);

    // ==========================================================
    // Entry-side nets
    // ==========================================================
    logic           [RS_DEPTH-1:0] busy;
    logic           [RS_DEPTH-1:0] wake_ready;
    logic           [RS_DEPTH-1:0] entry_write;
    logic           [RS_DEPTH-1:0] issue_en;
    rs_in_packet    [RS_DEPTH-1:0] entry_write_packet;
    rs_issue_packet [RS_DEPTH-1:0] entry_info;

    // Free-entry picks for dispatch
    rs_alloc alloc0 (
        .clock              (clock),
        .reset              (reset),
        .rs_in              (rs_in),
        .busy               (busy),
        .entry_write        (entry_write),
        .entry_write_packet (entry_write_packet),
        .struct_stall       (struct_stall)
    );

    // ==========================================================
    // Station entries
    // ==========================================================
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        rs_entry entry0 (
            .clock        (clock),
            .reset        (reset),
            .entry_write  (entry_write[i]),
            .write_packet (entry_write_packet[i]),
            .cdb          (cdb),
            .issue_en     (issue_en[i]),
            .busy         (busy[i]),
            .wake_ready   (wake_ready[i]),
            .entry_info   (entry_info[i])
        );
    end

    // Up to three ready micro-ops leave per cycle
    rs_issue_select select0 (
        .clock       (clock),
        .reset       (reset),
        .busy        (busy),
        .wake_ready  (wake_ready),
        .entry_info  (entry_info),
        .fu_stall    (fu_stall),
        .issue_en    (issue_en),
        .issue_insts (issue_insts)
    );

endmodule

/* verilog/rs_issue_select.sv */
`timescale 1ns/1ps

module rs_issue_select import rs_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  logic           [RS_DEPTH-1:0]   busy,
    input  logic           [RS_DEPTH-1:0]   wake_ready,
    input  rs_issue_packet [RS_DEPTH-1:0]   entry_info,
    input  fu_stall_packet                  fu_stall,
    output logic           [RS_DEPTH-1:0]   issue_en,
    output rs_issue_packet [DISPATCH_W-1:0] issue_insts
);

    logic [RS_DEPTH-1:0]                 fu_open;   // Entry's FU queue takes work
    logic [RS_DEPTH-1:0]                 issuable;
    logic [DISPATCH_W-1:0][RS_DEPTH-1:0] grant;     // One-hot entry per issue slot
    logic [DISPATCH_W-1:0][RS_DEPTH-1:0] remain;    // Candidates left before each pick

    // ==========================================================
    // Candidate mask
    // ==========================================================
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            case (entry_info[i].fu_sel)
                FU_ALU:    fu_open[i] = ~fu_stall.alu;
                FU_LS:     fu_open[i] = ~fu_stall.ls;
                FU_MULT:   fu_open[i] = ~fu_stall.mult;
                FU_BRANCH: fu_open[i] = ~fu_stall.branch;
                default:   fu_open[i] = 1'b0;
            endcase
        end
    end

    assign issuable = busy & wake_ready & fu_open;

    // ==========================================================
    // Grants
    // ==========================================================
    // Lowest index goes to slot 2, then slot 1, then slot 0
    always_comb begin
        remain = '0;
        grant  = '0;
        remain[DISPATCH_W-1] = issuable;
        for (int s = DISPATCH_W - 1; s >= 0; s--) begin
            grant[s] = first_set(remain[s]);
            if (s > 0) begin
                remain[s-1] = remain[s] & ~grant[s];
            end
        end
    end

    always_comb begin
        issue_en = '0;
        for (int s = 0; s < DISPATCH_W; s++) begin
            issue_en = issue_en | grant[s];  // Clears busy at the next edge
        end
    end

    // ==========================================================
    // Issue packets
    // ==========================================================
    always_comb begin
        issue_insts = '0;
        for (int s = 0; s < DISPATCH_W; s++) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (grant[s][i]) begin
                    issue_insts[s] = entry_info[i];
                end
            end
            issue_insts[s].valid = |grant[s];  // Empty slots stay invalid
        end
    end

    // Overlapping grants would send one micro-op down two issue slots
    a_grants_disjoint: assert property (
        @(posedge clock) disable iff (reset)
        $countones(issue_en) == $countones(grant)
    ) else $error("rs_issue_select: overlapping grants %h", grant);

endmodule

/* verilog/rs_entry.sv */
`timescale 1ns/1ps

module rs_entry import rs_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  logic           entry_write,
    input  rs_in_packet    write_packet,
    input  cdb_packet      cdb,
    input  logic           issue_en,
    output logic           busy,
    output logic           wake_ready,
    output rs_issue_packet entry_info
);

    logic reg1_ready;      // Stored operand state
    logic reg2_ready;
    logic reg1_ready_now;  // Stored state or a tag hit this cycle
    logic reg2_ready_now;

    // True when any valid broadcast slot carries this tag
    function automatic logic cdb_hit(input cdb_packet bus, input logic [PR_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < DISPATCH_W; s++) begin
            if (bus.slot[s].valid && bus.slot[s].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ==========================================================
    // Wakeup
    // ==========================================================
    assign reg1_ready_now = reg1_ready | cdb_hit(cdb, entry_info.reg1_pr);
    assign reg2_ready_now = reg2_ready | cdb_hit(cdb, entry_info.reg2_pr);
    assign wake_ready     = reg1_ready_now & reg2_ready_now;  // Same-cycle path to issue

    // ==========================================================
    // State
    // ==========================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (entry_write) begin
            busy <= 1'b1;
        end else if (issue_en) begin
            busy <= 1'b0;  // Free for allocation from the next cycle
        end
    end

    always_ff @(posedge clock) begin
        if (entry_write) begin
            entry_info <= write_packet.info;
            reg1_ready <= write_packet.reg1_ready;
            reg2_ready <= write_packet.reg2_ready;
        end else if (busy) begin
            // Keep any broadcast seen while waiting
            reg1_ready <= reg1_ready_now;
            reg2_ready <= reg2_ready_now;
        end
    end

    // Allocator and issue selector must never claim the same entry in one cycle
    a_write_vs_issue: assert property (
        @(posedge clock) disable iff (reset)
        !(entry_write && issue_en)
    ) else $error("rs_entry: write and issue in the same cycle");

    // Only an occupied entry may be picked for issue
    a_issue_busy: assert property (
        @(posedge clock) disable iff (reset)
        issue_en |-> busy
    ) else $error("rs_entry: issue of a free entry");

endmodule

/* verilog/rs_alloc.sv */
`timescale 1ns/1ps

module rs_alloc import rs_pkg::*; (
    input  logic                         clock,
    input  logic                         reset,
    input  rs_in_packet [DISPATCH_W-1:0] rs_in,
    input  logic        [RS_DEPTH-1:0]   busy,
    output logic        [RS_DEPTH-1:0]   entry_write,
    output rs_in_packet [RS_DEPTH-1:0]   entry_write_packet,
    output logic        [DISPATCH_W-1:0] struct_stall
);

    logic [DISPATCH_W-1:0][RS_DEPTH-1:0] grant;   // One-hot entry per dispatch slot
    logic [DISPATCH_W-1:0][RS_DEPTH-1:0] remain;  // Free entries left before each pick

    // ==========================================================
    // Free entry picks
    // ==========================================================
    // Slot 2 takes the lowest free entry, slot 1 the next, slot 0 the next
    always_comb begin
        remain = '0;
        grant  = '0;
        remain[DISPATCH_W-1] = ~busy;
        for (int s = DISPATCH_W - 1; s >= 0; s--) begin
            grant[s] = first_set(remain[s]);
            if (s > 0) begin
                remain[s-1] = remain[s] & ~grant[s];  // Hide earlier grants
            end
        end
    end

    // A slot that found no entry must hold its micro-op upstream
    always_comb begin
        for (int s = 0; s < DISPATCH_W; s++) begin
            struct_stall[s] = ~|grant[s];
        end
    end

    // ==========================================================
    // Steering into entries
    // ==========================================================
    // Grants are disjoint, so at most one slot hits each entry
    always_comb begin
        entry_write        = '0;
        entry_write_packet = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int s = 0; s < DISPATCH_W; s++) begin
                if (grant[s][i] && rs_in[s].info.valid) begin
                    entry_write[i]        = 1'b1;
                    entry_write_packet[i] = rs_in[s];
                end
            end
        end
    end

    // Entries report busy from their own registers, so this ties the two sides together
    a_write_to_free: assert property (
        @(posedge clock) disable iff (reset)
        (entry_write & busy) == '0
    ) else $error("rs_alloc: write to busy entry mask %h", entry_write & busy);

    // A freshly written entry must show busy on the next cycle
    a_write_sticks: assert property (
        @(posedge clock) disable iff (reset)
        entry_write != '0 |=> ($past(entry_write) & ~busy) == '0
    ) else $error("rs_alloc: written entry not busy afterwards");

endmodule

/* verilog/rs_pkg.sv */
package rs_pkg;

    // ==========================================================
    // Sizes
    // ==========================================================
    localparam int RS_DEPTH   = 16;  // Station entries
    localparam int DISPATCH_W = 3;   // Dispatch and issue width
    localparam int PR_W       = 6;   // Physical register tag

    // ==========================================================
    // Micro-op packets
    // ==========================================================
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LS     = 2'd1,
        FU_MULT   = 2'd2,
        FU_BRANCH = 2'd3
    } fu_class_t;

    // What the FU queues receive on issue
    typedef struct packed {
        logic            valid;
        fu_class_t       fu_sel;
        logic [4:0]      op_sel;
        logic [31:0]     pc;
        logic [31:0]     inst;
        logic [PR_W-1:0] dest_pr;
        logic [PR_W-1:0] reg1_pr;
        logic [PR_W-1:0] reg2_pr;
    } rs_issue_packet;

    // One dispatched micro-op from rename
    typedef struct packed {
        rs_issue_packet info;
        logic           reg1_ready;  // Source 1 value already available
        logic           reg2_ready;
    } rs_in_packet;

    // ==========================================================
    // Broadcast and back-pressure
    // ==========================================================
    typedef struct packed {
        logic            valid;
        logic [PR_W-1:0] tag;
    } cdb_slot_t;

    // One slot per completing result this cycle
    typedef struct packed {
        cdb_slot_t [DISPATCH_W-1:0] slot;
    } cdb_packet;

    // High when that FU queue cannot take more work
    typedef struct packed {
        logic alu;
        logic ls;
        logic mult;
        logic branch;
    } fu_stall_packet;

    // ==========================================================
    // Helpers
    // ==========================================================
    // One-hot lowest set bit, all zero for an empty vector
    function automatic logic [RS_DEPTH-1:0] first_set(input logic [RS_DEPTH-1:0] vec);
        logic [RS_DEPTH-1:0] neg;
        neg = ~vec + 1'b1;  // Two's complement keeps only the lowest one in common
        return vec & neg;
    endfunction

endpackage
